// File: verilog/renkon_pkg.sv
`default_nettype none

package renkon_pkg;

  // data path widths
  localparam int DWIDTH = 16;
  localparam int AWIDTH = 32;

  // memory address widths
  localparam int IMGSIZE        = 10;
  localparam int RENKON_NETSIZE = 8;
  localparam int OUTSIZE        = 6;

  // core array
  localparam int RENKON_CORE    = 2;
  localparam int RENKON_CORELOG = 1;

  localparam int LWIDTH      = 8;
  localparam int RENKON_FRAC = 8;

  typedef logic signed [DWIDTH-1:0] data_t;
  typedef logic signed [AWIDTH-1:0] acc_t;
  typedef logic [IMGSIZE-1:0]        img_addr_t;
  typedef logic [RENKON_NETSIZE-1:0] net_addr_t;
  typedef logic [LWIDTH-1:0]         len_t;
  typedef logic [OUTSIZE-1:0]        pix_addr_t;

  // 0 is idle, 1..RENKON_CORE selects a core
  typedef logic [RENKON_CORELOG:0] core_sel_t;

endpackage

`default_nettype wire

// File: verilog/renkon_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_ctrl (
  input  wire                         clk,
  input  wire                         xrst,
  input  wire                         req,
  input  wire renkon_pkg::len_t       total_in,
  input  wire renkon_pkg::len_t       total_out,
  input  wire renkon_pkg::len_t       img_size,
  input  wire renkon_pkg::img_addr_t  in_offset,
  input  wire renkon_pkg::img_addr_t  out_offset,
  input  wire renkon_pkg::net_addr_t  net_offset,
  input  wire                         out_we,
  input  wire renkon_pkg::data_t      out_wdata,
  input  wire                         serial_end,
  output logic                        ack,
  output logic                        img_we,
  output renkon_pkg::img_addr_t       img_addr,
  output renkon_pkg::data_t           img_wdata,
  output renkon_pkg::net_addr_t       net_rd_addr,
  output logic                        wreg_we,
  output logic                        breg_we,
  output logic                        pix_valid,
  output renkon_pkg::pix_addr_t       pix_addr,
  output logic                        first_input,
  output logic                        last_input,
  output logic                        serial_start,
  output renkon_pkg::core_sel_t       serial_cores
);

  typedef enum logic [1:0] {
    S_WAIT,
    S_NETWORK,
    S_INPUT,
    S_OUTPUT
  } state_t;

  state_t                state;
  logic                  req_d;
  logic                  req_edge;
  logic                  first_chan;
  logic                  last_chan;
  logic                  last_group;
  logic                  net_end;
  logic                  in_end;
  renkon_pkg::len_t      total_in_r;
  renkon_pkg::len_t      total_out_r;
  renkon_pkg::len_t      img_size_r;
  renkon_pkg::len_t      count_in;
  renkon_pkg::len_t      count_out;
  renkon_pkg::len_t      step;
  renkon_pkg::len_t      remaining;
  renkon_pkg::img_addr_t in_offset_r;
  renkon_pkg::img_addr_t in_addr;
  renkon_pkg::img_addr_t out_addr;
  renkon_pkg::net_addr_t net_base;

  // ====================================================================
  // sequencing
  // ====================================================================

  // only a rising req in S_WAIT starts a run
  assign req_edge   = req && !req_d && state == S_WAIT;
  assign first_chan = count_in == '0;
  assign last_chan  = count_in == total_in_r - renkon_pkg::len_t'(1);
  assign last_group = count_out + renkon_pkg::len_t'(renkon_pkg::RENKON_CORE) >= total_out_r;

  // first channel of a group also fetches the bias
  assign net_end = !first_chan || step == renkon_pkg::len_t'(1);
  assign in_end  = step == img_size_r - renkon_pkg::len_t'(1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_WAIT;
      req_d     <= 1'b0;
      ack       <= 1'b1;
      count_in  <= '0;
      count_out <= '0;
      step      <= '0;
    end else begin
      req_d <= req;
      case (state)
        S_WAIT: begin
          if (req_edge) begin
            state     <= S_NETWORK;
            ack       <= 1'b0;
            count_in  <= '0;
            count_out <= '0;
            step      <= '0;
          end
        end
        S_NETWORK: begin
          if (net_end) begin
            state <= S_INPUT;
            step  <= '0;
          end else begin
            step <= step + renkon_pkg::len_t'(1);
          end
        end
        S_INPUT: begin
          if (in_end) begin
            step <= '0;
            if (last_chan) begin
              state    <= S_OUTPUT;
              count_in <= '0;
            end else begin
              state    <= S_NETWORK;
              count_in <= count_in + renkon_pkg::len_t'(1);
            end
          end else begin
            step <= step + renkon_pkg::len_t'(1);
          end
        end
        S_OUTPUT: begin
          if (serial_end) begin
            if (last_group) begin
              state <= S_WAIT;
              ack   <= 1'b1;
            end else begin
              state     <= S_NETWORK;
              count_out <= count_out + renkon_pkg::len_t'(renkon_pkg::RENKON_CORE);
            end
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  // ====================================================================
  // addresses
  // ====================================================================

  always_ff @(posedge clk) begin
    if (req_edge) begin
      total_in_r  <= total_in;
      total_out_r <= total_out;
      img_size_r  <= img_size;
      in_offset_r <= in_offset;
      in_addr     <= in_offset;
      out_addr    <= out_offset;
      net_base    <= net_offset;
    end else begin
      if (state == S_INPUT) begin
        in_addr <= in_addr + renkon_pkg::img_addr_t'(1);
      end
      if (img_we) begin
        out_addr <= out_addr + renkon_pkg::img_addr_t'(1);
      end
      // next group rereads the inputs with the next weight block
      if (state == S_OUTPUT && serial_end) begin
        in_addr  <= in_offset_r;
        net_base <= net_base + renkon_pkg::net_addr_t'(total_in_r)
                    + renkon_pkg::net_addr_t'(1);
      end
    end
  end

  // weight of this channel or the bias at the end of the block
  assign net_rd_addr = net_base + ((step == '0) ? renkon_pkg::net_addr_t'(count_in)
                                                : renkon_pkg::net_addr_t'(total_in_r));

  assign img_we    = out_we && state == S_OUTPUT;
  assign img_addr  = (state == S_OUTPUT) ? out_addr : in_addr;
  assign img_wdata = out_wdata;

  assign remaining    = total_out_r - count_out;
  assign serial_cores = (remaining >= renkon_pkg::len_t'(renkon_pkg::RENKON_CORE))
                        ? renkon_pkg::core_sel_t'(renkon_pkg::RENKON_CORE)
                        : renkon_pkg::core_sel_t'(remaining);

  // ====================================================================
  // datapath strobes one cycle behind the reads
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wreg_we      <= 1'b0;
      breg_we      <= 1'b0;
      pix_valid    <= 1'b0;
      first_input  <= 1'b0;
      last_input   <= 1'b0;
      serial_start <= 1'b0;
    end else begin
      wreg_we      <= state == S_NETWORK && step == '0;
      breg_we      <= state == S_NETWORK && step == renkon_pkg::len_t'(1);
      pix_valid    <= state == S_INPUT;
      first_input  <= state == S_INPUT && first_chan;
      last_input   <= state == S_INPUT && last_chan;
      serial_start <= state == S_INPUT && in_end && last_chan;
    end
  end

  always_ff @(posedge clk) begin
    pix_addr <= renkon_pkg::pix_addr_t'(step);
  end

endmodule

`default_nettype wire

// File: verilog/renkon_img_mem.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_img_mem (
  input  wire                        clk,
  input  wire                        host_we,
  input  wire renkon_pkg::img_addr_t host_addr,
  input  wire renkon_pkg::data_t     host_wdata,
  input  wire                        eng_we,
  input  wire renkon_pkg::img_addr_t eng_addr,
  input  wire renkon_pkg::data_t     eng_wdata,
  output renkon_pkg::data_t          host_rdata,
  output renkon_pkg::data_t          eng_rdata
);

  renkon_pkg::data_t mem [2**renkon_pkg::IMGSIZE];

  // host and engine never run at once
  always_ff @(posedge clk) begin
    if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
    if (eng_we) begin
      mem[eng_addr] <= eng_wdata;
    end
    host_rdata <= mem[host_addr];
    eng_rdata  <= mem[eng_addr];
  end

endmodule

`default_nettype wire

// File: verilog/renkon_net_mem.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_net_mem (
  input  wire                        clk,
  input  wire                        net_we,
  input  wire renkon_pkg::core_sel_t net_sel,
  input  wire renkon_pkg::net_addr_t net_addr,
  input  wire renkon_pkg::data_t     net_wdata,
  input  wire renkon_pkg::net_addr_t rd_addr,
  output wire [renkon_pkg::RENKON_CORE*renkon_pkg::DWIDTH-1:0] net_rdata
);

  for (genvar k = 0; k < renkon_pkg::RENKON_CORE; k++) begin : g_bank
    renkon_pkg::data_t mem [2**renkon_pkg::RENKON_NETSIZE];
    renkon_pkg::data_t rdata;
    logic              bank_we;

    // bank k answers to select k+1
    assign bank_we = net_we && net_sel == renkon_pkg::core_sel_t'(k + 1);

    always_ff @(posedge clk) begin
      if (bank_we) begin
        mem[net_addr] <= net_wdata;
      end
      rdata <= mem[rd_addr];
    end

    assign net_rdata[k*renkon_pkg::DWIDTH +: renkon_pkg::DWIDTH] = rdata;
  end

endmodule

`default_nettype wire

// File: verilog/renkon_core.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_core (
  input  wire                        clk,
  input  wire                        xrst,
  input  wire renkon_pkg::data_t     net_rdata,
  input  wire                        wreg_we,
  input  wire                        breg_we,
  input  wire                        pix_valid,
  input  wire renkon_pkg::pix_addr_t pix_addr,
  input  wire renkon_pkg::data_t     pix_data,
  input  wire                        first_input,
  input  wire                        last_input,
  input  wire                        serial_re_hit,
  input  wire renkon_pkg::pix_addr_t serial_addr,
  output renkon_pkg::data_t          result
);

  renkon_pkg::data_t weight;
  renkon_pkg::data_t bias;
  renkon_pkg::acc_t  acc_mem [2**renkon_pkg::OUTSIZE];
  renkon_pkg::data_t res_mem [2**renkon_pkg::OUTSIZE];
  renkon_pkg::acc_t  prod;
  renkon_pkg::acc_t  prev;
  renkon_pkg::acc_t  sum;

  function automatic renkon_pkg::data_t saturate(input renkon_pkg::acc_t value);
    renkon_pkg::acc_t shifted;
    renkon_pkg::acc_t hi;
    renkon_pkg::acc_t lo;
    hi      = renkon_pkg::acc_t'(2 ** (renkon_pkg::DWIDTH - 1) - 1);
    lo      = -hi - renkon_pkg::acc_t'(1);
    shifted = value >>> renkon_pkg::RENKON_FRAC;
    if (shifted > hi) begin
      return renkon_pkg::data_t'(hi);
    end
    if (shifted < lo) begin
      return renkon_pkg::data_t'(lo);
    end
    return renkon_pkg::data_t'(shifted);
  endfunction

  always_ff @(posedge clk) begin
    if (wreg_we) begin
      weight <= net_rdata;
    end
    if (breg_we) begin
      bias <= net_rdata;
    end
  end

  // bias seeds the sum on the first channel
  always_comb begin
    prod = renkon_pkg::acc_t'(weight) * renkon_pkg::acc_t'(pix_data);
    prev = first_input ? renkon_pkg::acc_t'(bias) : acc_mem[pix_addr];
    sum  = prev + prod;
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      acc_mem[pix_addr] <= sum;
      if (last_input) begin
        res_mem[pix_addr] <= saturate(sum);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      result <= '0;
    end else if (serial_re_hit) begin
      result <= res_mem[serial_addr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/renkon_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_serializer (
  input  wire                        clk,
  input  wire                        xrst,
  input  wire                        serial_start,
  input  wire renkon_pkg::core_sel_t serial_cores,
  input  wire renkon_pkg::len_t      img_size,
  input  wire [renkon_pkg::RENKON_CORE*renkon_pkg::DWIDTH-1:0] core_rdata,
  output renkon_pkg::core_sel_t      serial_re,
  output renkon_pkg::pix_addr_t      serial_addr,
  output logic                       out_we,
  output renkon_pkg::data_t          out_wdata,
  output logic                       serial_end
);

  renkon_pkg::core_sel_t cores_r;
  renkon_pkg::core_sel_t sel_d;
  logic                  pix_last;
  logic                  last_rd;

  assign pix_last = renkon_pkg::len_t'(serial_addr) == img_size - renkon_pkg::len_t'(1);
  assign last_rd  = serial_re != '0 && serial_re == cores_r && pix_last;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      serial_re  <= '0;
      sel_d      <= '0;
      out_we     <= 1'b0;
      serial_end <= 1'b0;
    end else begin
      sel_d      <= serial_re;
      out_we     <= serial_re != '0;
      serial_end <= last_rd;
      if (serial_start) begin
        serial_re <= renkon_pkg::core_sel_t'(1);
      end else if (serial_re != '0 && pix_last) begin
        if (last_rd) begin
          serial_re <= '0;
        end else begin
          serial_re <= serial_re + renkon_pkg::core_sel_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (serial_start) begin
      cores_r     <= serial_cores;
      serial_addr <= '0;
    end else if (serial_re != '0) begin
      if (pix_last) begin
        serial_addr <= '0;
      end else begin
        serial_addr <= serial_addr + renkon_pkg::pix_addr_t'(1);
      end
    end
  end

  // core data arrives one cycle after its select
  always_comb begin
    out_wdata = '0;
    for (int k = 0; k < renkon_pkg::RENKON_CORE; k++) begin
      if (sel_d == renkon_pkg::core_sel_t'(k + 1)) begin
        out_wdata = core_rdata[k*renkon_pkg::DWIDTH +: renkon_pkg::DWIDTH];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/renkon_top.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_top (
  input  wire                        clk,
  input  wire                        xrst,
  input  wire                        req,
  output wire                        ack,
  input  wire                        host_img_we,
  input  wire renkon_pkg::img_addr_t host_img_addr,
  input  wire renkon_pkg::data_t     host_img_wdata,
  output wire renkon_pkg::data_t     host_img_rdata,
  input  wire                        net_we,
  input  wire renkon_pkg::core_sel_t net_sel,
  input  wire renkon_pkg::net_addr_t net_addr,
  input  wire renkon_pkg::data_t     net_wdata,
  input  wire renkon_pkg::len_t      total_in,
  input  wire renkon_pkg::len_t      total_out,
  input  wire renkon_pkg::len_t      img_size,
  input  wire renkon_pkg::img_addr_t in_offset,
  input  wire renkon_pkg::img_addr_t out_offset,
  input  wire renkon_pkg::net_addr_t net_offset
);

  wire                        img_we;
  wire renkon_pkg::img_addr_t img_addr;
  wire renkon_pkg::data_t     img_wdata;
  wire renkon_pkg::data_t     img_rdata;
  wire renkon_pkg::net_addr_t net_rd_addr;
  wire                        wreg_we;
  wire                        breg_we;
  wire                        pix_valid;
  wire renkon_pkg::pix_addr_t pix_addr;
  wire                        first_input;
  wire                        last_input;
  wire                        serial_start;
  wire renkon_pkg::core_sel_t serial_cores;
  wire renkon_pkg::core_sel_t serial_re;
  wire renkon_pkg::pix_addr_t serial_addr;
  wire                        out_we;
  wire renkon_pkg::data_t     out_wdata;
  wire                        serial_end;
  wire [renkon_pkg::RENKON_CORE-1:0]                   serial_re_hit;
  wire [renkon_pkg::RENKON_CORE*renkon_pkg::DWIDTH-1:0] net_rdata;
  wire [renkon_pkg::RENKON_CORE*renkon_pkg::DWIDTH-1:0] core_rdata;

  renkon_ctrl renkon_ctrl_inst (
    .clk          (clk),
    .xrst         (xrst),
    .req          (req),
    .total_in     (total_in),
    .total_out    (total_out),
    .img_size     (img_size),
    .in_offset    (in_offset),
    .out_offset   (out_offset),
    .net_offset   (net_offset),
    .out_we       (out_we),
    .out_wdata    (out_wdata),
    .serial_end   (serial_end),
    .ack          (ack),
    .img_we       (img_we),
    .img_addr     (img_addr),
    .img_wdata    (img_wdata),
    .net_rd_addr  (net_rd_addr),
    .wreg_we      (wreg_we),
    .breg_we      (breg_we),
    .pix_valid    (pix_valid),
    .pix_addr     (pix_addr),
    .first_input  (first_input),
    .last_input   (last_input),
    .serial_start (serial_start),
    .serial_cores (serial_cores)
  );

  renkon_img_mem renkon_img_mem_inst (
    .clk        (clk),
    .host_we    (host_img_we),
    .host_addr  (host_img_addr),
    .host_wdata (host_img_wdata),
    .eng_we     (img_we),
    .eng_addr   (img_addr),
    .eng_wdata  (img_wdata),
    .host_rdata (host_img_rdata),
    .eng_rdata  (img_rdata)
  );

  renkon_net_mem renkon_net_mem_inst (
    .clk       (clk),
    .net_we    (net_we),
    .net_sel   (net_sel),
    .net_addr  (net_addr),
    .net_wdata (net_wdata),
    .rd_addr   (net_rd_addr),
    .net_rdata (net_rdata)
  );

  for (genvar k = 0; k < renkon_pkg::RENKON_CORE; k++) begin : g_core
    assign serial_re_hit[k] = serial_re == renkon_pkg::core_sel_t'(k + 1);

    renkon_core renkon_core_inst (
      .clk           (clk),
      .xrst          (xrst),
      .net_rdata     (net_rdata[k*renkon_pkg::DWIDTH +: renkon_pkg::DWIDTH]),
      .wreg_we       (wreg_we),
      .breg_we       (breg_we),
      .pix_valid     (pix_valid),
      .pix_addr      (pix_addr),
      .pix_data      (img_rdata),
      .first_input   (first_input),
      .last_input    (last_input),
      .serial_re_hit (serial_re_hit[k]),
      .serial_addr   (serial_addr),
      .result        (core_rdata[k*renkon_pkg::DWIDTH +: renkon_pkg::DWIDTH])
    );
  end

  renkon_serializer renkon_serializer_inst (
    .clk          (clk),
    .xrst         (xrst),
    .serial_start (serial_start),
    .serial_cores (serial_cores),
    .img_size     (img_size),
    .core_rdata   (core_rdata),
    .serial_re    (serial_re),
    .serial_addr  (serial_addr),
    .out_we       (out_we),
    .out_wdata    (out_wdata),
    .serial_end   (serial_end)
  );

endmodule

`default_nettype wire

// File: bench/renkon_checker.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_checker (
  input  wire                        clk,
  input  wire                        xrst,
  input  wire                        req,
  input  wire                        ack,
  input  wire                        host_img_we,
  input  wire renkon_pkg::img_addr_t host_img_addr,
  input  wire renkon_pkg::data_t     host_img_rdata,
  output int                         errors,
  output int                         tests_done,
  output logic                       done
);

  localparam int PAT_WORDS = 256;
  localparam int MAX_TESTS = 16;
  localparam int HDR_WORDS = 10;

  logic [15:0] pat [PAT_WORDS];
  int          out_base [MAX_TESTS];
  int          exp_base [MAX_TESTS];
  int          exp_count [MAX_TESTS];
  int          n_tests;
  int          ack_errors;
  int          data_errors;
  logic        req_q;
  logic        ack_q;
  logic        armed;
  logic        after_reset;

  assign errors = ack_errors + data_errors;

  // ====================================================================
  // handshake
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_q       <= 1'b0;
      ack_q       <= 1'b1;
      armed       <= 1'b0;
      after_reset <= 1'b1;
      ack_errors  <= 0;
    end else begin
      req_q       <= req;
      ack_q       <= ack;
      after_reset <= 1'b0;
      if (after_reset && !ack) begin
        $display("ERR time=%0t signal=ack expected=1 got=%b", $time, ack);
        ack_errors <= ack_errors + 1;
      end
      if (ack_q && !ack) begin
        if (!armed) begin
          $display("ack fell at %0t without a new rising edge on req", $time);
          ack_errors <= ack_errors + 1;
        end
        armed <= 1'b0;
      end
      // a new run may only start from a rising req while idle
      if (req && !req_q && ack) begin
        armed <= 1'b1;
      end
    end
  end

  // ====================================================================
  // readback compare
  // ====================================================================

  initial begin
    int                    p;
    int                    bad;
    renkon_pkg::img_addr_t addr;
    logic [15:0]           expected;
    data_errors = 0;
    tests_done  = 0;
    done        = 1'b0;
    $readmemh("bench/renkon_patterns.txt", pat);
    n_tests = int'(pat[0]);
    p = 1;
    for (int t = 0; t < n_tests; t++) begin
      out_base[t]  = int'(pat[p+4]);
      exp_count[t] = int'(pat[p+1]) * int'(pat[p+2]) + 2;
      exp_base[t]  = p + HDR_WORDS + int'(pat[p+8])
                     + renkon_pkg::RENKON_CORE * int'(pat[p+9]);
      p = exp_base[t] + exp_count[t];
    end
    @(posedge xrst);
    for (int t = 0; t < n_tests; t++) begin
      @(negedge ack);
      @(posedge ack);
      bad = 0;
      for (int i = 0; i < exp_count[t]; i++) begin
        addr     = renkon_pkg::img_addr_t'(out_base[t] + i);
        expected = pat[exp_base[t] + i];
        do @(posedge clk); while (host_img_we || host_img_addr != addr);
        // registered read data is stable by the falling edge
        @(negedge clk);
        if (host_img_rdata !== expected) begin
          $display("ERR time=%0t signal=host_img_rdata addr=%h expected=%h got=%h",
                   $time, addr, expected, host_img_rdata);
          bad++;
        end
      end
      data_errors += bad;
      tests_done++;
      $display("test %0d: %0d of %0d words %s", t + 1, exp_count[t] - bad, exp_count[t],
               (bad == 0) ? "ok" : "wrong");
    end
    done = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/renkon_tb.sv
`timescale 1ns/10ps
`default_nettype none

module renkon_tb;

  localparam int CLK_NS    = 10;
  localparam int PAT_WORDS = 256;
  localparam int HDR_WORDS = 10;

  logic                   clk;
  logic                   xrst;
  logic                   req;
  wire                    ack;
  logic                   host_img_we;
  renkon_pkg::img_addr_t  host_img_addr;
  renkon_pkg::data_t      host_img_wdata;
  wire renkon_pkg::data_t host_img_rdata;
  logic                   net_we;
  renkon_pkg::core_sel_t  net_sel;
  renkon_pkg::net_addr_t  net_addr;
  renkon_pkg::data_t      net_wdata;
  renkon_pkg::len_t       total_in;
  renkon_pkg::len_t       total_out;
  renkon_pkg::len_t       img_size;
  renkon_pkg::img_addr_t  in_offset;
  renkon_pkg::img_addr_t  out_offset;
  renkon_pkg::net_addr_t  net_offset;
  logic [15:0]            pat [PAT_WORDS];
  logic [31:0]            lfsr;
  int                     budget_ns;
  int                     errors;
  int                     tests_done;
  logic                   checks_done;

  renkon_top renkon_top_inst (
    .clk            (clk),
    .xrst           (xrst),
    .req            (req),
    .ack            (ack),
    .host_img_we    (host_img_we),
    .host_img_addr  (host_img_addr),
    .host_img_wdata (host_img_wdata),
    .host_img_rdata (host_img_rdata),
    .net_we         (net_we),
    .net_sel        (net_sel),
    .net_addr       (net_addr),
    .net_wdata      (net_wdata),
    .total_in       (total_in),
    .total_out      (total_out),
    .img_size       (img_size),
    .in_offset      (in_offset),
    .out_offset     (out_offset),
    .net_offset     (net_offset)
  );

  renkon_checker renkon_checker_inst (
    .clk            (clk),
    .xrst           (xrst),
    .req            (req),
    .ack            (ack),
    .host_img_we    (host_img_we),
    .host_img_addr  (host_img_addr),
    .host_img_rdata (host_img_rdata),
    .errors         (errors),
    .tests_done     (tests_done),
    .done           (checks_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // ====================================================================
  // host helpers called on a falling edge
  // ====================================================================

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic idle_gap();
    int n;
    random_bits(2, n);
    repeat (n) @(negedge clk);
  endtask

  task automatic write_img(input renkon_pkg::img_addr_t addr, input logic [15:0] data);
    host_img_we    = 1'b1;
    host_img_addr  = addr;
    host_img_wdata = data;
    @(negedge clk);
    host_img_we = 1'b0;
    idle_gap();
  endtask

  task automatic write_net(input renkon_pkg::core_sel_t sel, input renkon_pkg::net_addr_t addr,
                           input logic [15:0] data);
    net_we    = 1'b1;
    net_sel   = sel;
    net_addr  = addr;
    net_wdata = data;
    @(negedge clk);
    net_we = 1'b0;
    idle_gap();
  endtask

  task automatic read_img(input renkon_pkg::img_addr_t addr);
    host_img_addr = addr;
    @(negedge clk);
  endtask

  function automatic int budget_cycles(input int n_tests);
    int p;
    int total;
    int n_in;
    int n_pix;
    int n_exp;
    int groups;
    p     = 1;
    total = 0;
    for (int t = 0; t < n_tests; t++) begin
      n_in   = int'(pat[p]);
      n_pix  = int'(pat[p+2]);
      n_exp  = int'(pat[p+1]) * n_pix + 2;
      groups = (int'(pat[p+1]) + renkon_pkg::RENKON_CORE - 1) / renkon_pkg::RENKON_CORE;
      total += n_exp + int'(pat[p+8]) + renkon_pkg::RENKON_CORE * int'(pat[p+9]);
      total += groups * (n_in * (n_pix + 1) + 1 + renkon_pkg::RENKON_CORE * n_pix + 3);
      total += n_exp;
      p += HDR_WORDS + int'(pat[p+8]) + renkon_pkg::RENKON_CORE * int'(pat[p+9]) + n_exp;
    end
    return 20 * total;
  endfunction

  // ====================================================================
  // one test fills, loads, runs and reads back
  // ====================================================================

  task automatic run_test(input int p, output int next);
    int n_exp;
    int q;
    n_exp = int'(pat[p+1]) * int'(pat[p+2]) + 2;
    for (int i = 0; i < n_exp; i++) begin
      write_img(renkon_pkg::img_addr_t'(int'(pat[p+4]) + i), pat[p+6]);
    end
    q = p + HDR_WORDS;
    for (int i = 0; i < int'(pat[p+8]); i++) begin
      write_img(renkon_pkg::img_addr_t'(int'(pat[p+7]) + i), pat[q+i]);
    end
    q += int'(pat[p+8]);
    for (int k = 0; k < renkon_pkg::RENKON_CORE; k++) begin
      for (int i = 0; i < int'(pat[p+9]); i++) begin
        write_net(renkon_pkg::core_sel_t'(k + 1),
                  renkon_pkg::net_addr_t'(int'(pat[p+5]) + i), pat[q+i]);
      end
      q += int'(pat[p+9]);
    end
    total_in   = renkon_pkg::len_t'(pat[p]);
    total_out  = renkon_pkg::len_t'(pat[p+1]);
    img_size   = renkon_pkg::len_t'(pat[p+2]);
    in_offset  = renkon_pkg::img_addr_t'(pat[p+3]);
    out_offset = renkon_pkg::img_addr_t'(pat[p+4]);
    net_offset = renkon_pkg::net_addr_t'(pat[p+5]);
    req = 1'b1;
    do @(negedge clk); while (ack);
    do @(negedge clk); while (!ack);
    for (int i = 0; i < n_exp; i++) begin
      read_img(renkon_pkg::img_addr_t'(int'(pat[p+4]) + i));
    end
    // req held past the end of the run
    repeat (4) @(negedge clk);
    req = 1'b0;
    @(negedge clk);
    next = q + n_exp;
  endtask

  initial begin
    int p;
    int next;
    int n_tests;
    xrst           = 1'b0;
    req            = 1'b0;
    host_img_we    = 1'b0;
    host_img_addr  = '0;
    host_img_wdata = '0;
    net_we         = 1'b0;
    net_sel        = '0;
    net_addr       = '0;
    net_wdata      = '0;
    total_in       = '0;
    total_out      = '0;
    img_size       = '0;
    in_offset      = '0;
    out_offset     = '0;
    net_offset     = '0;
    lfsr           = 32'hef85;
    $readmemh("bench/renkon_patterns.txt", pat);
    n_tests   = int'(pat[0]);
    budget_ns = (budget_cycles(n_tests) + 20) * CLK_NS;
    repeat (10) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);
    p = 1;
    for (int t = 0; t < n_tests; t++) begin
      run_test(p, next);
      p = next;
    end
    wait (checks_done);
    $display("summary: %0d of %0d tests checked, %0d errors", tests_done, n_tests, errors);
    if (errors == 0 && tests_done == n_tests) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (budget_ns > 0);
    #(budget_ns);
    $display("timeout: the run did not finish within %0d ns", budget_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/renkon_patterns.txt
// per test: total_in total_out img_size in_offset out_offset net_offset fill img_base img_count
// net_count, then image words, network words of core 1 and core 2, expected readback words
0005
// one channel, two filters
0001 0002 0004 0000 0100 0000 dead 0000 0004 0002
0100 0200 ff00 0080
0300 0100
ff80 0000
0301 0601 fd01 0181 ff80 ff00 0080 ffc0 dead dead
// three channels
0003 0002 0003 0010 0120 0000 beef 0010 0009 0004
0100 0200 0300 0010 0020 0030 ff00 0000 0100
0100 0200 0080 0400
ff00 0010 0000 fc00
00a4 0244 03e4 fefd fdfe fcff beef beef
// two groups, fourth map unused
0002 0003 0002 0020 0140 0000 5a5a 0020 0004 0006
0100 ff00 0200 0080
0100 0000 0000 0000 0100 0100
0080 0080 0000 7fff 7fff 7fff
0100 ff00 0180 ffc0 0201 0081 5a5a 5a5a
// saturation at both ends
0001 0002 0002 0030 0160 0000 1234 0030 0002 0002
7fff 8000
7fff 0000
8000 7fff
7fff 8000 8000 7fff 1234 1234
// offsets, guard words around the input block
0002 0002 0003 0081 0301 0040 cafe 0080 0008 0003
7fff 0010 0020 0030 0100 0200 ff00 7fff
1000 0100 0200
ff00 0040 0000
0202 0402 0202 0030 0060 ff90 cafe cafe

// File: flist.f
verilog/renkon_pkg.sv
verilog/renkon_ctrl.sv
verilog/renkon_img_mem.sv
verilog/renkon_net_mem.sv
verilog/renkon_core.sv
verilog/renkon_serializer.sv
verilog/renkon_top.sv
bench/renkon_checker.sv
bench/renkon_tb.sv

// File: Makefile
SRCS := $(shell cat flist.f)

obj_dir/Vrenkon_tb: flist.f $(SRCS) bench/renkon_patterns.txt
	verilator --binary --timing -Wno-fatal --top-module renkon_tb -f flist.f

run: obj_dir/Vrenkon_tb
	./obj_dir/Vrenkon_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
